/* verilog.f */
hdl/galaksija_av_pkg.sv
hdl/av_config_regs.sv
hdl/line_capture.sv
hdl/line_buffer.sv
hdl/scan_doubler.sv
hdl/sigma_delta_dac.sv
hdl/galaksija_av.sv
sim/tb_clock_gen.sv
sim/galaksija_av_tb.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= galaksija_av_tb
FILELIST ?= verilog.f

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/galaksija_av_tb.sv */
`timescale 1ns/10ps

module galaksija_av_tb import galaksija_av_pkg::*; ();

	// One input line is 360 pixel enables of 4 clocks each.
	localparam int line_ce = 360;
	localparam int line_clocks = line_ce * 4;
	localparam int cycle_limit = 6 * 8 * line_clocks + 4000;

	logic clk_sys, reset, psel, penable, pwrite, pready, pslverr;
	logic [11:0] paddr;
	logic [31:0] pwdata, prdata, rd;
	logic ce_pix, hsync_in, vsync_in, vga_hs, vga_vs, vga_de, audio_out, core_reset;
	logic [7:0] pix_in, audio_in;
	logic [5:0] vga_r, vga_g, vga_b;
	logic [31:0] lfsr = 32'h0e5a_c060;
	logic [7:0] line_q[$];
	logic err, in_reset, drive_done;
	int errors = 0, err_mark = 0, tests_ok = 0, tests_bad = 0, cycles = 0, edges_sent = 0;
	int ones;

	tb_clock_gen clk_inst (.clk_sys(clk_sys));

	galaksija_av galaksija_av_inst (.*);

	function automatic logic [17:0] expand_px(input logic [7:0] p);
		return {6'(p[2:0]) * 6'd9, 6'(p[5:3]) * 6'd9, 6'(p[7:6]) * 6'd5};
	endfunction

	function automatic logic [5:0] dim(input logic [5:0] c, input int m);
		if (m == 2)
			return c - c / 4;
		if (m == 3)
			return c - c / 2;
		return c;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		for (int i = 0; i < 8; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (errors == err_mark) ? "ok" : "FAILED");
		if (errors == err_mark)
			tests_ok++;
		else
			tests_bad++;
		err_mark = errors;
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] d);
		@(posedge clk_sys) #2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = a;
		pwdata = d;
		@(posedge clk_sys) #2;
		penable = 1'b1;
		@(negedge clk_sys);
		rd = prdata;
		err = pslverr;
		check("pready", pready, 1'b1);
		@(posedge clk_sys) #2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic ce_cycle(input logic hs, input logic [7:0] p);
		@(posedge clk_sys) #2;
		ce_pix = 1'b1;
		hsync_in = hs;
		pix_in = p;
		@(posedge clk_sys) #2;
		ce_pix = 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// Line j is captured between sync edges j and j+1 and played after edge j+1.
	task automatic drive_lines(input int n);
		logic [7:0] p;
		drive_done = 1'b0;
		edges_sent = 0;
		line_q = {};
		for (int e = 0; e <= n; e++) begin
			ce_cycle(1'b1, rand_byte());
			edges_sent++;
			for (int i = 1; i < line_ce; i++) begin
				p = rand_byte();
				if (i <= line_pixels && e < n)
					line_q.push_back(p);
				ce_cycle(1'b0, p);
			end
		end
		drive_done = 1'b1;
	endtask

	task automatic wait_de_rise();
		while (vga_de) @(negedge clk_sys);
		while (!vga_de) @(negedge clk_sys);
	endtask

	task automatic check_windows(input int n, input int mode);
		int cyc;
		logic [17:0] e;
		// The driver restarts its edge count first.
		@(negedge clk_sys);
		while (edges_sent < 2) @(negedge clk_sys);
		for (int j = 0; j < n; j++) begin
			for (int w = 0; w < 2; w++) begin
				wait_de_rise();
				cyc = 0;
				while (vga_de) begin
					e = expand_px(line_q[j * line_pixels + ((cyc / 2) % line_pixels)]);
					if (w == 1)
						e = {dim(e[17:12], mode), dim(e[11:6], mode), dim(e[5:0], mode)};
					check($sformatf("line %0d copy %0d pixel %0d", j, w, cyc / 2),
						{vga_r, vga_g, vga_b}, e);
					cyc++;
					@(negedge clk_sys);
				end
				check("window length", cyc, 2 * line_pixels);
			end
		end
	endtask

	task automatic check_bypass();
		logic [7:0] last;
		int seen;
		seen = 0;
		@(negedge clk_sys);
		last = pix_in;
		while (!drive_done) begin
			@(negedge clk_sys);
			if (vga_de) begin
				check("bypass pixel", {vga_r, vga_g, vga_b}, expand_px(last));
				seen++;
			end
			last = pix_in;
		end
		assert (seen > 0) else begin
			errors++;
			$display("Bypass mode never raised vga_de.");
		end
	endtask

	// Outputs must be quiet during reset and a few clocks after it.
	assert property (@(negedge clk_sys) in_reset |->
		!(vga_de || vga_hs || vga_vs || audio_out || core_reset))
	else begin
		errors++;
		$display("mismatch at %0t: outputs not low around reset", $time);
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clocks.", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		in_reset = 1'b1;
		drive_done = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ce_pix = 1'b0;
		hsync_in = 1'b0;
		vsync_in = 1'b0;
		pix_in = '0;
		audio_in = '0;
		repeat (16) @(posedge clk_sys);
		#2 reset = 1'b0;
		repeat (4) @(negedge clk_sys);
		in_reset = 1'b0;
		end_test("reset state");

		apb_xfer(1'b0, reg_status_addr, 0);
		check("status after reset", rd, 0);
		apb_xfer(1'b1, reg_status_addr, 32'h0000_020c);
		apb_xfer(1'b0, reg_status_addr, 0);
		check("status readback", rd, 32'h0000_020c);
		check("core_reset from bit 9", core_reset, 1'b1);
		apb_xfer(1'b1, reg_status_addr, 32'h0000_0001);
		check("core_reset from bit 0", core_reset, 1'b1);
		apb_xfer(1'b1, reg_status_addr, 32'h0000_0000);
		check("core_reset cleared", core_reset, 1'b0);
		apb_xfer(1'b0, reg_build_addr, 0);
		check("build id", rd, build_id);
		check("build read error", err, 1'b0);
		apb_xfer(1'b1, reg_build_addr, 32'h1234_5678);
		check("build write error", err, 1'b1);
		apb_xfer(1'b0, 12'h010, 0);
		check("unknown address error", err, 1'b1);
		check("unknown address data", rd, 0);
		end_test("apb registers");

		fork
			drive_lines(3);
			check_windows(3, 0);
		join
		end_test("line doubling");

		for (int m = 3; m >= 0; m--) begin
			apb_xfer(1'b1, reg_status_addr, 32'(m) << 2);
			fork
				drive_lines(2);
				check_windows(2, m);
			join
		end
		end_test("scanline dimming");

		// Bypass with dim_50 selected, which the direct path ignores.
		apb_xfer(1'b1, reg_status_addr, 32'h0000_000e);
		fork
			drive_lines(2);
			check_bypass();
		join
		apb_xfer(1'b1, reg_status_addr, 32'h0000_0000);
		end_test("bypass");

		for (int s = 0; s < 256; s += 51) begin
			@(posedge clk_sys) #2 audio_in = 8'(s);
			repeat (2) @(negedge clk_sys);
			ones = 0;
			repeat (512) begin
				@(negedge clk_sys);
				ones += int'(audio_out);
			end
			assert ((s == 0) ? (ones == 0) : (ones >= 2 * s - 1 && ones <= 2 * s + 1)) else begin
				errors++;
				$display("mismatch at %0t: audio %0d gave %0d ones", $time, s, ones);
			end
		end
		end_test("audio dac");

		$display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real period_ns = 40.0
) (
	output logic clk_sys
);

	initial begin
		clk_sys = 1'b0;
		forever #(period_ns / 2.0) clk_sys = ~clk_sys;
	end

endmodule

/* hdl/galaksija_av.sv */
`timescale 1ns/10ps

module galaksija_av import galaksija_av_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [11:0]      paddr,
	input  logic [31:0]      pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	input  logic             ce_pix,
	input  logic [pix_w-1:0] pix_in,
	input  logic             hsync_in,
	input  logic             vsync_in,
	input  logic [7:0]       audio_in,
	output logic [5:0]       vga_r,
	output logic [5:0]       vga_g,
	output logic [5:0]       vga_b,
	output logic             vga_hs,
	output logic             vga_vs,
	output logic             vga_de,
	output logic             audio_out,
	output logic             core_reset
);

	logic                  doubler_bypass;
	scanline_mode_t        scan_mode;
	logic                  wr_en;
	logic                  wr_bank;
	logic [buf_addr_w-1:0] wr_addr;
	logic [pix_w-1:0]      wr_data;
	logic                  line_done;
	logic                  done_bank;
	logic                  in_window;
	logic                  rd_bank;
	logic [buf_addr_w-1:0] rd_addr;
	logic [pix_w-1:0]      rd_data;

	av_config_regs av_config_regs_inst (
		.clk_sys(clk_sys), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .core_reset(core_reset),
		.doubler_bypass(doubler_bypass), .scan_mode(scan_mode)
	);

	line_capture line_capture_inst (
		.clk_sys(clk_sys), .reset(reset), .ce_pix(ce_pix), .pix_in(pix_in),
		.hsync_in(hsync_in), .vsync_in(vsync_in), .wr_en(wr_en), .wr_bank(wr_bank),
		.wr_addr(wr_addr), .wr_data(wr_data), .line_done(line_done),
		.done_bank(done_bank), .in_window(in_window)
	);

	line_buffer line_buffer_inst (
		.clk_sys(clk_sys), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
		.wr_data(wr_data), .rd_bank(rd_bank), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	scan_doubler scan_doubler_inst (
		.clk_sys(clk_sys), .reset(reset), .line_done(line_done), .done_bank(done_bank),
		.vsync_in(vsync_in), .pix_in(pix_in), .in_window(in_window),
		.doubler_bypass(doubler_bypass), .scan_mode(scan_mode), .rd_bank(rd_bank),
		.rd_addr(rd_addr), .rd_data(rd_data), .vga_r(vga_r), .vga_g(vga_g),
		.vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de)
	);

	sigma_delta_dac sigma_delta_dac_inst (
		.clk_sys(clk_sys), .reset(reset), .audio_in(audio_in), .audio_out(audio_out)
	);

endmodule

/* hdl/sigma_delta_dac.sv */
`timescale 1ns/10ps

module sigma_delta_dac (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] audio_in,
	output logic       audio_out
);

	logic [8:0] acc;

	// First order loop. The carry out of the low byte is the output bit.
	always_ff @(posedge clk_sys) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[7:0]} + {1'b0, audio_in};
	end

	// Pulse density follows the sample over 256 clocks.
	assign audio_out = acc[8];

endmodule

/* hdl/scan_doubler.sv */
`timescale 1ns/10ps

module scan_doubler import galaksija_av_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  line_done,
	input  logic                  done_bank,
	input  logic                  vsync_in,
	input  logic [pix_w-1:0]      pix_in,
	input  logic                  in_window,
	input  logic                  doubler_bypass,
	input  scanline_mode_t        scan_mode,
	output logic                  rd_bank,
	output logic [buf_addr_w-1:0] rd_addr,
	input  logic [pix_w-1:0]      rd_data,
	output logic [5:0]            vga_r,
	output logic [5:0]            vga_g,
	output logic [5:0]            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_de
);

	logic [2:0]            state;
	logic [play_cnt_w-1:0] cnt;
	logic [period_w-1:0]   pos;
	logic [period_w-1:0]   period_cnt;
	logic [period_w-1:0]   half_len;
	logic                  second;
	logic                  blank_done;
	logic                  play_start;
	logic                  rd_valid;
	logic                  rd_second;
	logic                  vs_hold;
	logic                  vs_line;
	logic [17:0]           pix_rgb;
	scanline_mode_t        line_mode;

	// 3-3-2 to 6-6-6 by repeating the field bits.
	function automatic logic [17:0] expand(input logic [pix_w-1:0] p);
		return {p[2:0], p[2:0], p[5:3], p[5:3], 2'b00, p[7:6], p[7:6]};
	endfunction

	function automatic logic [5:0] shade(input logic [5:0] c, input scanline_mode_t m);
		logic [5:0] r;
		case (m)
			scan_dim_25: r = c - (c >> 2);
			scan_dim_50: r = c - (c >> 1);
			default: r = c;
		endcase
		return r;
	endfunction

	// Each output line lasts half the measured input line.
	assign blank_done = (state == st_blank) && (pos >= half_len);
	assign play_start = line_done || (blank_done && !second);
	assign rd_addr = cnt[play_cnt_w-1:1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			period_cnt <= '0;
			half_len <= '0;
		end else if (line_done) begin
			period_cnt <= '0;
			half_len <= {1'b0, period_cnt[period_w-1:1]};
		end else if (period_cnt != '1) begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			pos <= '0;
			second <= 1'b0;
			rd_bank <= 1'b0;
		end else if (line_done) begin
			// A new line restarts the pair even mid playout.
			state <= st_sync;
			cnt <= '0;
			pos <= 1;
			second <= 1'b0;
			rd_bank <= done_bank;
		end else begin
			cnt <= cnt + 1'b1;
			if (pos != '1)
				pos <= pos + 1'b1;
			case (state)
				st_sync: if (cnt == play_cnt_w'(hs_clocks - 1)) begin
					state <= st_porch;
					cnt <= '0;
				end
				st_porch: if (cnt == play_cnt_w'(bp_clocks - 1)) begin
					state <= st_active;
					cnt <= '0;
				end
				st_active: if (cnt == play_cnt_w'(2*line_pixels - 1)) begin
					state <= st_blank;
					cnt <= '0;
				end
				st_blank: if (blank_done) begin
					cnt <= '0;
					pos <= 1;
					second <= 1'b1;
					state <= second ? st_idle : st_sync;
				end
				default: cnt <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_valid <= 1'b0;
			rd_second <= 1'b0;
			vs_hold <= 1'b0;
			vs_line <= 1'b0;
			vga_de <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			rd_valid <= (state == st_active);
			rd_second <= second;
			if (play_start) begin
				vs_hold <= vsync_in;
				vs_line <= vs_hold;
			end
			if (doubler_bypass) begin
				vga_de <= in_window;
				vga_hs <= (state == st_sync) && !second;
				vga_vs <= vsync_in;
			end else begin
				vga_de <= rd_valid;
				vga_hs <= (state == st_sync);
				vga_vs <= vs_line;
			end
		end
	end

	// Only the repeated line is dimmed.
	always_comb begin
		pix_rgb = expand(doubler_bypass ? pix_in : rd_data);
		line_mode = (rd_second && !doubler_bypass) ? scan_mode : scan_none;
	end

	always_ff @(posedge clk_sys) begin
		vga_r <= shade(pix_rgb[17:12], line_mode);
		vga_g <= shade(pix_rgb[11:6], line_mode);
		vga_b <= shade(pix_rgb[5:0], line_mode);
	end

endmodule

/* hdl/line_buffer.sv */
`timescale 1ns/10ps

module line_buffer import galaksija_av_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  wr_en,
	input  logic                  wr_bank,
	input  logic [buf_addr_w-1:0] wr_addr,
	input  logic [pix_w-1:0]      wr_data,
	input  logic                  rd_bank,
	input  logic [buf_addr_w-1:0] rd_addr,
	output logic [pix_w-1:0]      rd_data
);

	logic [pix_w-1:0]    mem [0:2*line_pixels-1];
	logic [buf_addr_w:0] wr_idx;
	logic [buf_addr_w:0] rd_idx;

	// Bank 1 sits directly above bank 0.
	assign wr_idx = wr_bank ? ({1'b0, wr_addr} + (buf_addr_w+1)'(line_pixels)) : {1'b0, wr_addr};
	assign rd_idx = rd_bank ? ({1'b0, rd_addr} + (buf_addr_w+1)'(line_pixels)) : {1'b0, rd_addr};

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_idx] <= wr_data;
	end

	// Registered read port.
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_idx];
	end

endmodule

/* hdl/line_capture.sv */
`timescale 1ns/10ps

module line_capture import galaksija_av_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ce_pix,
	input  logic [pix_w-1:0]      pix_in,
	input  logic                  hsync_in,
	input  logic                  vsync_in,
	output logic                  wr_en,
	output logic                  wr_bank,
	output logic [buf_addr_w-1:0] wr_addr,
	output logic [pix_w-1:0]      wr_data,
	output logic                  line_done,
	output logic                  done_bank,
	output logic                  in_window
);

	logic                  hs_prev;
	logic                  vs_prev;
	logic                  hs_rise;
	logic                  vs_rise;
	logic [buf_addr_w-1:0] pix_cnt;

	// Sync edges are only seen on pixel enable cycles.
	assign hs_rise = ce_pix && hsync_in && !hs_prev;
	assign vs_rise = ce_pix && vsync_in && !vs_prev;

	// Window closes once a full line has been stored.
	assign in_window = (pix_cnt < buf_addr_w'(line_pixels));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			pix_cnt <= buf_addr_w'(line_pixels);
			wr_bank <= 1'b0;
			done_bank <= 1'b0;
			line_done <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			line_done <= hs_rise;
			wr_en <= ce_pix && !hs_rise && in_window;
			if (ce_pix) begin
				hs_prev <= hsync_in;
				vs_prev <= vsync_in;
			end
			if (hs_rise) begin
				pix_cnt <= '0;
				done_bank <= wr_bank;
				wr_bank <= ~wr_bank;
			end else if (ce_pix && in_window) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// Line parity restarts on bank 0 with each frame.
			if (vs_rise)
				wr_bank <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ce_pix) begin
			wr_addr <= pix_cnt;
			wr_data <= pix_in;
		end
	end

endmodule

/* hdl/av_config_regs.sv */
`timescale 1ns/10ps

module av_config_regs import galaksija_av_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           psel,
	input  logic           penable,
	input  logic           pwrite,
	input  logic [11:0]    paddr,
	input  logic [31:0]    pwdata,
	output logic [31:0]    prdata,
	output logic           pready,
	output logic           pslverr,
	output logic           core_reset,
	output logic           doubler_bypass,
	output scanline_mode_t scan_mode
);

	status_word_u status;
	logic         access;
	logic         status_hit;
	logic         build_hit;

	assign access = psel && penable;
	assign status_hit = (paddr == reg_status_addr);
	assign build_hit = (paddr == reg_build_addr);

	// Every transfer completes in its first access cycle.
	assign pready = 1'b1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status.raw <= '0;
		end else if (access && pwrite && status_hit) begin
			status.raw <= pwdata;
		end
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (status_hit)
				prdata = status.raw;
			else if (build_hit)
				prdata = build_id;
		end
	end

	// The build word is read only.
	assign pslverr = access && !(status_hit || (build_hit && !pwrite));

	// Either the reset bit or the menu reset request holds the core.
	assign core_reset = status.fields.core_reset | status.fields.reset_request;
	assign doubler_bypass = status.fields.doubler_bypass;

	always_comb begin
		case (status.fields.scanline)
			2'd2: scan_mode = scan_dim_25;
			2'd3: scan_mode = scan_dim_50;
			// Code 1 selected HQ2x, which is not built here.
			default: scan_mode = scan_none;
		endcase
	end

endmodule

/* hdl/galaksija_av_pkg.sv */
package galaksija_av_pkg;

	// Video line geometry.
	localparam int line_pixels = 320;
	localparam int pix_w = 8;
	localparam int buf_addr_w = 9;

	// Output line timing in clk_sys cycles.
	localparam int hs_clocks = 16;
	localparam int bp_clocks = 8;
	localparam int period_w = 12;
	localparam int play_cnt_w = buf_addr_w + 1;

	// Scandoubler FSM encoding.
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_sync = 3'd1;
	localparam logic [2:0] st_porch = 3'd2;
	localparam logic [2:0] st_active = 3'd3;
	localparam logic [2:0] st_blank = 3'd4;

	// APB register map.
	localparam logic [11:0] reg_status_addr = 12'h000;
	localparam logic [11:0] reg_build_addr = 12'h004;
	localparam logic [31:0] build_id = 32'h6a5c_0100;

	typedef struct packed {
		logic [21:0] unused;
		logic        reset_request;
		logic [4:0]  reserved;
		logic [1:0]  scanline;
		logic        doubler_bypass;
		logic        core_reset;
	} status_fields_t;

	// Written as a raw word over APB, read as fields by the video path.
	typedef union packed {
		logic [31:0]    raw;
		status_fields_t fields;
	} status_word_u;

	typedef enum logic [1:0] {
		scan_none   = 2'd0,
		scan_dim_25 = 2'd2,
		scan_dim_50 = 2'd3
	} scanline_mode_t;

endpackage
